//--- tomasulo_dispatch.f
+incdir+source
source/tomasulo_pkg.sv
source/regfile.sv
source/reg_status_table.sv
source/tag_fifo.sv
source/dispatch_ctrl.sv
source/dispatch_unit.sv
verification/dispatch_unit_tb.sv

//--- verification/dispatch_unit_tb.sv
`include "tomasulo_cfg.svh"

module dispatch_unit_tb import tomasulo_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD  = 8;
   localparam int STEP_CYCLES = 60;
   localparam operand_t RDY   = '0;

   typedef enum logic [1:0] {
      K_ISSUE,
      K_JUMP,
      K_BRANCH,
      K_CDB
   } step_kind_e;

   // ready_low marks the queues held not ready for a while
   typedef struct packed {
      step_kind_e         kind;
      logic [31:0]        inst;
      logic [31:0]        pc4;
      logic [3:0]         ready_low;
      cdb_t               bus;
      queue_sel_e         exp_q;
      issue_t             exp_issue;
      redirect_t          exp_redir;
      logic               dbg;
      logic [`REG_W-1:0]  dbg_addr;
      logic [`DATA_W-1:0] dbg_data;
   } step_t;

   logic               clk;
   logic               rst;
   logic [31:0]        ifq_inst;
   logic [31:0]        ifq_pc_plus4;
   logic               ifq_empty;
   logic               ifq_ren;
   redirect_t          redirect;
   issue_t             issue;
   logic               ls_en;
   logic               int_en;
   logic               mult_en;
   logic               div_en;
   // Ready levels indexed by queue_sel_e
   logic [3:0]         ready;
   cdb_t               cdb;
   logic [`REG_W-1:0]  debug_addr;
   logic [`DATA_W-1:0] debug_data;

   step_t      steps [$];
   logic       table_ready;
   logic [7:0] lfsr_state;

   dispatch_unit u_dispatch_unit (
      .clk         (clk),
      .rst         (rst),
      .ifq_inst    (ifq_inst),
      .ifq_pc_plus4(ifq_pc_plus4),
      .ifq_empty   (ifq_empty),
      .ifq_ren     (ifq_ren),
      .redirect    (redirect),
      .issue       (issue),
      .ls_en       (ls_en),
      .int_en      (int_en),
      .mult_en     (mult_en),
      .div_en      (div_en),
      .ls_ready    (ready[Q_LS]),
      .int_ready   (ready[Q_INT]),
      .mult_ready  (ready[Q_MULT]),
      .div_ready   (ready[Q_DIV]),
      .cdb         (cdb),
      .debug_addr  (debug_addr),
      .debug_data  (debug_data)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Fibonacci LFSR with polynomial x^8 + x^6 + x^5 + x^4 + 1
   function automatic logic [7:0] lfsr_step(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
   endfunction

   function automatic int random_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = (v << 1) | int'(lfsr_state[0]);
      end
      return v;
   endfunction

   function automatic logic [31:0] rtype(input int rs, input int rt, input int rd,
                                         input logic [5:0] fn);
      return {`OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
   endfunction

   function automatic logic [31:0] itype(input logic [5:0] op, input int rs, input int rt,
                                         input int imm);
      return {op, 5'(rs), 5'(rt), 16'(imm)};
   endfunction

   function automatic operand_t pending(input int t);
      operand_t o;
      o.tag  = tag_t'(t);
      o.busy = 1'b1;
      return o;
   endfunction

   // Pending operands carry the producer tag
   // Ready operands carry data and tag 0
   function automatic issue_t expected_issue(input logic [31:0] inst, input int rd_tag,
         input operand_t rs, input logic [31:0] rs_d, input operand_t rt,
         input logic [31:0] rt_d, input ls_op_e ls, input int_op_e op);
      issue_t e;
      e.imm      = inst[15:0];
      e.rd_tag   = tag_t'(rd_tag);
      e.rs_tag   = rs.busy ? rs.tag : '0;
      e.rt_tag   = rt.busy ? rt.tag : '0;
      e.rs_data  = rs_d;
      e.rt_data  = rt_d;
      e.rs_valid = !rs.busy;
      e.rt_valid = !rt.busy;
      e.ls_op    = ls;
      e.int_op   = op;
      return e;
   endfunction

   function automatic cdb_t result_word(input int t, input logic [31:0] d);
      cdb_t c;
      c       = '0;
      c.valid = 1'b1;
      c.tag   = tag_t'(t);
      c.data  = d;
      return c;
   endfunction

   function automatic cdb_t outcome_word(input logic taken);
      cdb_t c;
      c              = '0;
      c.valid        = 1'b1;
      c.branch       = 1'b1;
      c.branch_taken = taken;
      return c;
   endfunction

   function automatic redirect_t redirect_to(input logic [31:0] addr);
      redirect_t r;
      r.valid = 1'b1;
      r.addr  = addr;
      return r;
   endfunction

   task automatic issue_row(input logic [31:0] inst, input logic [3:0] ready_low,
                            input cdb_t bus, input queue_sel_e q, input issue_t exp);
      step_t s;
      s           = '0;
      s.kind      = K_ISSUE;
      s.inst      = inst;
      s.pc4       = 32'h0000_0040;
      s.ready_low = ready_low;
      s.bus       = bus;
      s.exp_q     = q;
      s.exp_issue = exp;
      steps.push_back(s);
   endtask

   task automatic control_row(input step_kind_e kind, input logic [31:0] inst,
                              input logic [31:0] pc4, input cdb_t bus, input redirect_t redir);
      step_t s;
      s           = '0;
      s.kind      = kind;
      s.inst      = inst;
      s.pc4       = pc4;
      s.bus       = bus;
      s.exp_redir = redir;
      steps.push_back(s);
   endtask

   // Adds a debug port read to the last row
   task automatic attach_debug(input int addr, input logic [31:0] data);
      step_t s;
      s          = steps.pop_back();
      s.dbg      = 1'b1;
      s.dbg_addr = 5'(addr);
      s.dbg_data = data;
      steps.push_back(s);
   endtask

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_issue(input issue_t got, input queue_sel_e got_q,
                              input issue_t exp, input queue_sel_e exp_q);
      if (got !== exp || got_q !== exp_q) begin
         stop_with_failure($sformatf("CHECK FAILED at %0d ns: issue %s %h, expected %s %h",
                                     $time, got_q.name(), got, exp_q.name(), exp));
      end
   endtask

   task automatic check_redirect(input redirect_t got, input redirect_t exp);
      if (got.valid !== exp.valid || (exp.valid && got.addr !== exp.addr)) begin
         stop_with_failure($sformatf("CHECK FAILED at %0d ns: redirect %b/%h, expected %b/%h",
                                     $time, got.valid, got.addr, exp.valid, exp.addr));
      end
   endtask

   task automatic check_data(input logic [`DATA_W-1:0] got, input logic [`DATA_W-1:0] exp,
                             input logic [`REG_W-1:0] addr);
      if (got !== exp) begin
         stop_with_failure($sformatf("CHECK FAILED at %0d ns: r%0d reads %h, expected %h",
                                     $time, addr, got, exp));
      end
   endtask

   task automatic build_table();
      int          recycled [4];
      logic [31:0] w;
      recycled = '{0, 1, 3, 2};
      // Independent instructions straight after reset take tags 0, 1, 2 in order
      w = rtype(2, 3, 1, `FN_ADD);
      issue_row(w, 4'h0, '0, Q_INT, expected_issue(w, 0, RDY, '0, RDY, '0, LS_LOAD, INT_ADD));
      w = itype(`OP_ADDI, 5, 4, 7);
      issue_row(w, 4'h0, '0, Q_INT, expected_issue(w, 1, RDY, '0, RDY, '0, LS_LOAD, INT_ADDI));
      w = rtype(2, 3, 6, `FN_MULT);
      issue_row(w, 4'h0, '0, Q_MULT, expected_issue(w, 2, RDY, '0, RDY, '0, LS_LOAD, INT_ADD));
      w = rtype(2, 3, 7, `FN_DIV);
      issue_row(w, 4'h0, '0, Q_DIV, expected_issue(w, 3, RDY, '0, RDY, '0, LS_LOAD, INT_ADD));
      w = itype(`OP_LW, 2, 8, 4);
      issue_row(w, 4'h0, '0, Q_LS, expected_issue(w, 4, RDY, '0, RDY, '0, LS_LOAD, INT_ADD));
      // Store has no destination and takes no tag
      w = itype(`OP_SW, 2, 3, 8);
      issue_row(w, 4'h0, '0, Q_LS, expected_issue(w, 0, RDY, '0, RDY, '0, LS_STORE, INT_ADD));
      // r1 and r4 still wait on tags 0 and 1
      w = rtype(1, 4, 9, `FN_SUB);
      issue_row(w, 4'h0, '0, Q_INT,
                expected_issue(w, 5, pending(0), '0, pending(1), '0, LS_LOAD, INT_SUB));
      // Tag 0 result lands in r1
      control_row(K_CDB, '0, '0, result_word(0, 32'h1234_5678), '0);
      attach_debug(1, 32'h1234_5678);
      w = rtype(1, 4, 10, `FN_AND);
      issue_row(w, 4'h0, '0, Q_INT,
                expected_issue(w, 6, RDY, 32'h1234_5678, pending(1), '0, LS_LOAD, INT_AND));
      // Tag 1 broadcast in the dispatch cycle itself is forwarded
      w = rtype(4, 0, 11, `FN_OR);
      issue_row(w, 4'h0, result_word(1, 32'hcafe_0001), Q_INT,
                expected_issue(w, 7, RDY, 32'hcafe_0001, RDY, '0, LS_LOAD, INT_OR));
      attach_debug(4, 32'hcafe_0001);
      // Integer then multiply queue not ready for a few cycles
      w = rtype(1, 4, 12, `FN_SLT);
      issue_row(w, 4'b0010, '0, Q_INT,
                expected_issue(w, 8, RDY, 32'h1234_5678, RDY, 32'hcafe_0001, LS_LOAD, INT_SLT));
      w = rtype(1, 1, 13, `FN_MULT);
      issue_row(w, 4'b0100, '0, Q_MULT,
                expected_issue(w, 9, RDY, 32'h1234_5678, RDY, 32'h1234_5678, LS_LOAD, INT_ADD));
      // Tags 3 and 2 return out of order
      control_row(K_CDB, '0, '0, result_word(3, 32'h0000_0033), '0);
      attach_debug(7, 32'h0000_0033);
      control_row(K_CDB, '0, '0, result_word(2, 32'h0000_0022), '0);
      attach_debug(6, 32'h0000_0022);
      // Jump field -16 from pc_plus4 0x100
      control_row(K_JUMP, {`OP_J, 26'h3ff_fff0}, 32'h0000_0100, '0, redirect_to(32'h0000_00f0));
      // Taken beq targets 0x200 plus 3 words
      control_row(K_BRANCH, itype(`OP_BEQ, 1, 4, 3), 32'h0000_0200, '0, '0);
      control_row(K_CDB, '0, '0, outcome_word(1'b1), redirect_to(32'h0000_020c));
      control_row(K_BRANCH, itype(`OP_BEQ, 1, 1, 16'hfffe), 32'h0000_0300, '0, '0);
      control_row(K_CDB, '0, '0, outcome_word(1'b0), '0);
      w = rtype(0, 0, 14, `FN_ADD);
      issue_row(w, 4'h0, '0, Q_INT, expected_issue(w, 10, RDY, '0, RDY, '0, LS_LOAD, INT_ADD));
      // Drain tags 11 to 63 before the returned ones come back in return order
      for (int i = 0; i < 57; i++) begin
         w = rtype(0, 0, 15 + i % 17, `FN_ADD);
         issue_row(w, 4'h0, '0, Q_INT, expected_issue(w, (i < 53) ? 11 + i : recycled[i - 53],
                                                       RDY, '0, RDY, '0, LS_LOAD, INT_ADD));
      end
   endtask

   task automatic run_step(input step_t s);
      int         hold;
      logic [3:0] en;
      queue_sel_e got_q;
      hold  = (s.ready_low != 4'h0) ? 1 + random_bits(3) : 0;
      got_q = Q_LS;
      @(posedge clk);
      cdb        <= s.bus;
      ready      <= ~s.ready_low;
      debug_addr <= s.dbg_addr;
      if (s.kind == K_CDB) begin
         // Bus word lives for exactly one cycle
         @(posedge clk);
         cdb <= '0;
      end else begin
         ifq_inst     <= s.inst;
         ifq_pc_plus4 <= s.pc4;
         ifq_empty    <= 1'b0;
         repeat (hold) begin
            @(negedge clk);
            if (ifq_ren || {div_en, mult_en, int_en, ls_en} != 4'h0) begin
               stop_with_failure("instruction dispatched while its queue was not ready");
            end
         end
         if (hold > 0) begin
            @(posedge clk);
            ready <= 4'hf;
         end
         @(negedge clk);
         while (!ifq_ren) @(negedge clk);
         // Instruction is taken on this edge
         @(posedge clk);
         ifq_empty <= 1'b1;
         cdb       <= '0;
      end
      @(negedge clk);
      en = {div_en, mult_en, int_en, ls_en};
      case (s.kind)
         K_ISSUE: begin
            if ($countones(en) != 1) begin
               stop_with_failure("no single queue enable pulse one cycle after dispatch");
            end
            for (int i = 0; i < 4; i++) begin
               if (en[i]) got_q = queue_sel_e'(i);
            end
            check_issue(issue, got_q, s.exp_issue, s.exp_q);
            @(negedge clk);
            if ({div_en, mult_en, int_en, ls_en} != 4'h0) begin
               stop_with_failure("queue enable stayed high for more than one cycle");
            end
         end
         K_JUMP: begin
            check_redirect(redirect, s.exp_redir);
            if (en != 4'h0) stop_with_failure("jump was issued to an execution queue");
         end
         K_BRANCH: begin
            if (en != 4'h0 || ifq_ren || redirect.valid) begin
               stop_with_failure("beq was issued, redirected early or did not stall the IFQ");
            end
         end
         default: begin
            check_redirect(redirect, s.exp_redir);
            if (en != 4'h0) stop_with_failure("queue enable pulsed on a bus-only cycle");
         end
      endcase
      if (s.dbg) check_data(debug_data, s.dbg_data, s.dbg_addr);
   endtask

   // Limit scales with the table length
   initial begin
      wait (table_ready);
      #((steps.size() * STEP_CYCLES + 8) * CLK_PERIOD);
      stop_with_failure("watchdog timeout, the test sequence did not finish in time");
   end

   initial begin
      rst          = 1'b1;
      ifq_inst     = '0;
      ifq_pc_plus4 = '0;
      ifq_empty    = 1'b1;
      ready        = 4'hf;
      cdb          = '0;
      debug_addr   = '0;
      lfsr_state   = 8'd68;
      table_ready  = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (7) @(posedge clk);
      @(negedge clk);
      if (ifq_ren || redirect.valid || {div_en, mult_en, int_en, ls_en} != 4'h0) begin
         stop_with_failure("ifq_ren, a queue enable or the redirect was high during reset");
      end
      @(posedge clk);
      rst <= 1'b0;
      foreach (steps[i]) begin
         run_step(steps[i]);
      end
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

//--- source/dispatch_unit.sv
`include "tomasulo_cfg.svh"

module dispatch_unit import tomasulo_pkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  logic [31:0]        ifq_inst,
   input  logic [31:0]        ifq_pc_plus4,
   input  logic               ifq_empty,
   output logic               ifq_ren,
   output redirect_t          redirect,
   output issue_t             issue,
   output logic               ls_en,
   output logic               int_en,
   output logic               mult_en,
   output logic               div_en,
   input  logic               ls_ready,
   input  logic               int_ready,
   input  logic               mult_ready,
   input  logic               div_ready,
   input  cdb_t               cdb,
   input  logic [`REG_W-1:0]  debug_addr,
   output logic [`DATA_W-1:0] debug_data
);

   logic [`REG_W-1:0]    rs_addr;
   logic [`REG_W-1:0]    rt_addr;
   logic [`REG_W-1:0]    rd_addr;
   logic [`DATA_W-1:0]   rs_data;
   logic [`DATA_W-1:0]   rt_data;
   operand_t             rs_status;
   operand_t             rt_status;
   tag_t                 free_tag;
   logic                 tag_empty;
   logic                 alloc;
   // Status table tells the regfile which registers take the CDB result
   logic [`NUM_REGS-1:0] wen_onehot;

   dispatch_ctrl u_ctrl (
      .clk         (clk),
      .rst         (rst),
      .ifq_inst    (ifq_inst),
      .ifq_pc_plus4(ifq_pc_plus4),
      .ifq_empty   (ifq_empty),
      .ifq_ren     (ifq_ren),
      .redirect    (redirect),
      .rs_addr     (rs_addr),
      .rt_addr     (rt_addr),
      .rd_addr     (rd_addr),
      .rs_data     (rs_data),
      .rt_data     (rt_data),
      .rs_status   (rs_status),
      .rt_status   (rt_status),
      .free_tag    (free_tag),
      .tag_empty   (tag_empty),
      .alloc       (alloc),
      .cdb         (cdb),
      .issue       (issue),
      .ls_en       (ls_en),
      .int_en      (int_en),
      .mult_en     (mult_en),
      .div_en      (div_en),
      .ls_ready    (ls_ready),
      .int_ready   (int_ready),
      .mult_ready  (mult_ready),
      .div_ready   (div_ready)
   );

   regfile u_regfile (
      .clk       (clk),
      .rst       (rst),
      .rs_addr   (rs_addr),
      .rt_addr   (rt_addr),
      .debug_addr(debug_addr),
      .rs_data   (rs_data),
      .rt_data   (rt_data),
      .debug_data(debug_data),
      .wen_onehot(wen_onehot),
      .cdb       (cdb)
   );

   reg_status_table u_status (
      .clk       (clk),
      .rst       (rst),
      .rs_addr   (rs_addr),
      .rt_addr   (rt_addr),
      .rd_addr   (rd_addr),
      .alloc     (alloc),
      .free_tag  (free_tag),
      .cdb       (cdb),
      .rs_status (rs_status),
      .rt_status (rt_status),
      .wen_onehot(wen_onehot)
   );

   tag_fifo u_tag_fifo (
      .clk      (clk),
      .rst      (rst),
      .alloc    (alloc),
      .free_tag (free_tag),
      .tag_empty(tag_empty),
      .cdb      (cdb)
   );

endmodule

//--- source/dispatch_ctrl.sv
`include "tomasulo_cfg.svh"

module dispatch_ctrl import tomasulo_pkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  logic [31:0]        ifq_inst,
   input  logic [31:0]        ifq_pc_plus4,
   input  logic               ifq_empty,
   output logic               ifq_ren,
   output redirect_t          redirect,
   output logic [`REG_W-1:0]  rs_addr,
   output logic [`REG_W-1:0]  rt_addr,
   output logic [`REG_W-1:0]  rd_addr,
   input  logic [31:0]        rs_data,
   input  logic [31:0]        rt_data,
   input  operand_t           rs_status,
   input  operand_t           rt_status,
   input  tag_t               free_tag,
   input  logic               tag_empty,
   output logic               alloc,
   input  cdb_t               cdb,
   output issue_t             issue,
   output logic               ls_en,
   output logic               int_en,
   output logic               mult_en,
   output logic               div_en,
   input  logic               ls_ready,
   input  logic               int_ready,
   input  logic               mult_ready,
   input  logic               div_ready
);

   logic [5:0]         opcode;
   logic [5:0]         funct;
   logic [`IMM_W-1:0]  imm;
   logic [25:0]        jaddr;
   queue_sel_e         q_sel;
   int_op_e            int_op;
   ls_op_e             ls_op;
   logic               to_queue;
   logic               has_dest;
   logic               is_beq;
   logic               is_jump;
   logic               needs_tag;
   logic               q_ready;
   logic               fire;
   logic               cdb_result;
   logic               rs_hit;
   logic               rt_hit;
   logic               rs_ok;
   logic               rt_ok;
   logic               branch_done;
   issue_t             payload;
   disp_state_e        state;
   logic               redir_valid;
   logic [`DATA_W-1:0] redir_addr;
   logic [`DATA_W-1:0] jump_target;
   logic [`DATA_W-1:0] branch_target;
   logic [`DATA_W-1:0] br_target_r;

   // R and I formats share the rs and rt fields
   assign opcode  = ifq_inst[31:26];
   assign rs_addr = ifq_inst[25:21];
   assign rt_addr = ifq_inst[20:16];
   assign funct   = ifq_inst[5:0];
   assign imm     = ifq_inst[15:0];
   assign jaddr   = ifq_inst[25:0];

   // Jump field is added unscaled
   assign jump_target   = ifq_pc_plus4 + {{6{jaddr[25]}}, jaddr};
   // Branch offset counts words
   assign branch_target = ifq_pc_plus4 + {{14{imm[15]}}, imm, 2'b00};

   always_comb begin
      q_sel    = Q_INT;
      int_op   = INT_ADD;
      ls_op    = LS_LOAD;
      to_queue = 1'b0;
      has_dest = 1'b0;
      rd_addr  = ifq_inst[20:16];
      is_beq   = 1'b0;
      is_jump  = 1'b0;
      case (opcode)
         `OP_RTYPE: begin
            to_queue = 1'b1;
            has_dest = 1'b1;
            rd_addr  = ifq_inst[15:11];
            case (funct)
               `FN_ADD:  int_op = INT_ADD;
               `FN_SUB:  int_op = INT_SUB;
               `FN_AND:  int_op = INT_AND;
               `FN_OR:   int_op = INT_OR;
               `FN_SLT:  int_op = INT_SLT;
               `FN_MULT: q_sel  = Q_MULT;
               `FN_DIV:  q_sel  = Q_DIV;
               default: begin
                  // Unknown function code is consumed without issue
                  to_queue = 1'b0;
                  has_dest = 1'b0;
               end
            endcase
         end
         `OP_ADDI: begin
            to_queue = 1'b1;
            has_dest = 1'b1;
            int_op   = INT_ADDI;
         end
         `OP_LW: begin
            to_queue = 1'b1;
            has_dest = 1'b1;
            q_sel    = Q_LS;
         end
         `OP_SW: begin
            to_queue = 1'b1;
            q_sel    = Q_LS;
            ls_op    = LS_STORE;
         end
         `OP_BEQ: is_beq  = 1'b1;
         `OP_J:   is_jump = 1'b1;
         default: ;
      endcase
   end

   // Writes to the hardwired register 0 never take a tag
   assign needs_tag = has_dest && (rd_addr != '0);

   always_comb begin
      case (q_sel)
         Q_LS:    q_ready = ls_ready;
         Q_INT:   q_ready = int_ready;
         Q_MULT:  q_ready = mult_ready;
         default: q_ready = div_ready;
      endcase
   end

   // Hold fetch in reset, while waiting on a branch and while a redirect is in flight
   assign ifq_ren = !rst && (state == ST_RUN) && !redir_valid &&
                    (!to_queue || q_ready) && (!needs_tag || !tag_empty);
   assign fire    = ifq_ren && !ifq_empty;
   assign alloc   = fire && needs_tag;

   // Same-cycle CDB result bypasses the regfile read
   assign cdb_result  = cdb.valid && !cdb.branch;
   assign branch_done = cdb.valid && cdb.branch;
   assign rs_hit = rs_status.busy && cdb_result && (cdb.tag == rs_status.tag);
   assign rt_hit = rt_status.busy && cdb_result && (cdb.tag == rt_status.tag);
   assign rs_ok  = !rs_status.busy || rs_hit;
   assign rt_ok  = !rt_status.busy || rt_hit;

   always_comb begin
      payload          = '0;
      payload.imm      = imm;
      payload.rd_tag   = needs_tag ? free_tag : '0;
      // Tag only meaningful while the operand is still pending
      payload.rs_tag   = rs_ok ? '0 : rs_status.tag;
      payload.rt_tag   = rt_ok ? '0 : rt_status.tag;
      payload.rs_data  = rs_hit ? cdb.data : rs_data;
      payload.rt_data  = rt_hit ? cdb.data : rt_data;
      payload.rs_valid = rs_ok;
      payload.rt_valid = rt_ok;
      payload.ls_op    = ls_op;
      payload.int_op   = int_op;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= ST_RUN;
         redir_valid <= 1'b0;
         ls_en       <= 1'b0;
         int_en      <= 1'b0;
         mult_en     <= 1'b0;
         div_en      <= 1'b0;
      end else begin
         ls_en       <= fire && to_queue && (q_sel == Q_LS);
         int_en      <= fire && to_queue && (q_sel == Q_INT);
         mult_en     <= fire && to_queue && (q_sel == Q_MULT);
         div_en      <= fire && to_queue && (q_sel == Q_DIV);
         redir_valid <= fire && is_jump;
         case (state)
            ST_RUN: begin
               if (fire && is_beq) state <= ST_BRANCH_WAIT;
            end
            default: begin
               // Outcome word ends the wait and redirects only when taken
               if (branch_done) begin
                  state       <= ST_RUN;
                  redir_valid <= cdb.branch_taken;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (fire && to_queue) issue <= payload;
      if (fire && is_beq) br_target_r <= branch_target;
      if (fire && is_jump) redir_addr <= jump_target;
      else if (state == ST_BRANCH_WAIT) redir_addr <= br_target_r;
   end

   assign redirect = '{valid: redir_valid, addr: redir_addr};

   a_one_enable: assert property (@(posedge clk) disable iff (rst)
      $onehot0({ls_en, int_en, mult_en, div_en}));

   // Pop of an empty free list would hand out a stale tag
   a_alloc_has_tag: assert property (@(posedge clk) disable iff (rst)
      alloc |-> !tag_empty);

endmodule

//--- source/tag_fifo.sv
`include "tomasulo_cfg.svh"

module tag_fifo import tomasulo_pkg::*; (
   input  logic clk,
   input  logic rst,
   input  logic alloc,
   output tag_t free_tag,
   output logic tag_empty,
   input  cdb_t cdb
);

   tag_t            mem [`NUM_TAGS];
   // Pointers are tag wide and wrap at the ring size
   tag_t            rd_ptr;
   tag_t            wr_ptr;
   logic [`TAG_W:0] count;
   logic            push;

   // Every finished result frees its tag, branch words hold none
   assign push = cdb.valid && !cdb.branch;

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= `NUM_TAGS;
         // All tags start free, handed out in ascending order
         for (int i = 0; i < `NUM_TAGS; i++) begin
            mem[i] <= tag_t'(i);
         end
      end else begin
         if (push) begin
            mem[wr_ptr] <= cdb.tag;
            wr_ptr      <= wr_ptr + 1'b1;
         end
         if (alloc) rd_ptr <= rd_ptr + 1'b1;
         case ({push, alloc})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign free_tag  = mem[rd_ptr];
   assign tag_empty = (count == '0);

   // A return into a full ring means a tag was freed twice
   a_no_push_full: assert property (@(posedge clk) disable iff (rst)
      push |-> (count != `NUM_TAGS));

endmodule

//--- source/reg_status_table.sv
`include "tomasulo_cfg.svh"

module reg_status_table import tomasulo_pkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  logic [`REG_W-1:0]    rs_addr,
   input  logic [`REG_W-1:0]    rt_addr,
   input  logic [`REG_W-1:0]    rd_addr,
   input  logic                 alloc,
   input  tag_t                 free_tag,
   input  cdb_t                 cdb,
   output operand_t             rs_status,
   output operand_t             rt_status,
   output logic [`NUM_REGS-1:0] wen_onehot
);

   tag_t                 tags [`NUM_REGS];
   logic [`NUM_REGS-1:0] busy;
   logic [`NUM_REGS-1:0] match;
   logic [`NUM_REGS-1:0] alloc_hit;
   logic                 cdb_result;

   // Branch outcome words carry no result tag
   assign cdb_result = cdb.valid && !cdb.branch;

   always_comb begin
      for (int i = 0; i < `NUM_REGS; i++) begin
         match[i]     = busy[i] && cdb_result && (tags[i] == cdb.tag);
         alloc_hit[i] = alloc && (rd_addr == `REG_W'(i));
      end
   end

   // A register renamed this cycle drops the old producer's result
   assign wen_onehot = match & ~alloc_hit;

   always_ff @(posedge clk) begin
      if (rst) begin
         busy <= '0;
      end else begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            if (alloc_hit[i]) busy[i] <= 1'b1;
            else if (match[i]) busy[i] <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (alloc) tags[rd_addr] <= free_tag;
   end

   // Lookups see the state before this cycle's update
   assign rs_status = '{tag: tags[rs_addr], busy: busy[rs_addr]};
   assign rt_status = '{tag: tags[rt_addr], busy: busy[rt_addr]};

endmodule

//--- source/regfile.sv
`include "tomasulo_cfg.svh"

module regfile import tomasulo_pkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  logic [`REG_W-1:0]    rs_addr,
   input  logic [`REG_W-1:0]    rt_addr,
   input  logic [`REG_W-1:0]    debug_addr,
   output logic [`DATA_W-1:0]   rs_data,
   output logic [`DATA_W-1:0]   rt_data,
   output logic [`DATA_W-1:0]   debug_data,
   input  logic [`NUM_REGS-1:0] wen_onehot,
   input  cdb_t                 cdb
);

   logic [`DATA_W-1:0] regs [`NUM_REGS];

   // Several registers may wait on the same tag, all take the CDB data
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         // Register 0 stays zero
         for (int i = 1; i < `NUM_REGS; i++) begin
            if (wen_onehot[i]) regs[i] <= cdb.data;
         end
      end
   end

   assign rs_data    = regs[rs_addr];
   assign rt_data    = regs[rt_addr];
   assign debug_data = regs[debug_addr];

   a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
      !wen_onehot[0]);

endmodule

//--- source/tomasulo_pkg.sv
`include "tomasulo_cfg.svh"

package tomasulo_pkg;

   typedef logic [`TAG_W-1:0] tag_t;

   // Operation codes seen by the integer queue
   typedef enum logic [2:0] {
      INT_ADD,
      INT_SUB,
      INT_AND,
      INT_OR,
      INT_SLT,
      INT_ADDI
   } int_op_e;

   typedef enum logic {
      LS_LOAD,
      LS_STORE
   } ls_op_e;

   // Target execution queue
   typedef enum logic [1:0] {
      Q_LS,
      Q_INT,
      Q_MULT,
      Q_DIV
   } queue_sel_e;

   typedef enum logic {
      ST_RUN,
      ST_BRANCH_WAIT
   } disp_state_e;

   // Payload shared by all four execution queues
   typedef struct packed {
      logic [`IMM_W-1:0]  imm;
      tag_t               rd_tag;
      tag_t               rs_tag;
      tag_t               rt_tag;
      logic [`DATA_W-1:0] rs_data;
      logic [`DATA_W-1:0] rt_data;
      logic               rs_valid;
      logic               rt_valid;
      ls_op_e             ls_op;
      int_op_e            int_op;
   } issue_t;

   // Common data bus, branch words carry the outcome instead of a tag
   typedef struct packed {
      logic               valid;
      tag_t               tag;
      logic [`DATA_W-1:0] data;
      logic               branch;
      logic               branch_taken;
   } cdb_t;

   typedef struct packed {
      logic               valid;
      logic [`DATA_W-1:0] addr;
   } redirect_t;

   // Status table lookup for one source register
   typedef struct packed {
      tag_t tag;
      logic busy;
   } operand_t;

endpackage

//--- source/tomasulo_cfg.svh
`ifndef TOMASULO_CFG_SVH
`define TOMASULO_CFG_SVH

// Tag and register widths are fixed by the instruction format
`define TAG_W     6
`define NUM_TAGS  64
`define REG_W     5
`define NUM_REGS  32
`define DATA_W    32
`define IMM_W     16

// Primary opcodes, instruction bits 31:26
`define OP_RTYPE  6'b000000
`define OP_LW     6'b100011
`define OP_SW     6'b101011
`define OP_BEQ    6'b000100
`define OP_J      6'b000010
`define OP_ADDI   6'b001000

// R-type function codes, instruction bits 5:0
`define FN_ADD    6'h20
`define FN_SUB    6'h22
`define FN_AND    6'h24
`define FN_OR     6'h25
`define FN_SLT    6'h2a
`define FN_MULT   6'h18
`define FN_DIV    6'h1a

`endif
